// File: mem_bridge.f
source/mem_bridge_pkg.sv
source/axil_if.sv
source/mem_port_if.sv
source/req_arbiter.sv
source/axil_master.sv
source/axil_scratchpad.sv
source/mem_bridge_top.sv
verification/mem_bridge_asserts.sv
verification/tb_mem_bridge.sv

// File: source/axil_if.sv
`timescale 1ns/1ps

interface axil_if;
  import mem_bridge_pkg::*;

  // Write address
  logic [axil_addr_width_gp-1:0] awaddr;
  logic [2:0]                    awprot;
  logic                          awvalid;
  logic                          awready;

  // Write data
  logic [axil_data_width_gp-1:0] wdata;
  logic [axil_strb_width_gp-1:0] wstrb;
  logic                          wvalid;
  logic                          wready;

  // Write response
  logic [1:0]                    bresp;
  logic                          bvalid;
  logic                          bready;

  // Read address
  logic [axil_addr_width_gp-1:0] araddr;
  logic [2:0]                    arprot;
  logic                          arvalid;
  logic                          arready;

  // Read data
  logic [axil_data_width_gp-1:0] rdata;
  logic [1:0]                    rresp;
  logic                          rvalid;
  logic                          rready;

  modport master
  (
    output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready
    , output araddr, arprot, arvalid, rready
    , input awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport slave
  (
    input awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready
    , input araddr, arprot, arvalid, rready
    , output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

// File: source/axil_master.sv
`timescale 1ns/1ps

module axil_master
(
  input  logic         clk_i
  , input  logic       arst_n_i
  , mem_port_if.server req_i
  , axil_if.master     axil_o
);
  import mem_bridge_pkg::*;

  typedef enum logic [2:0]
  {
    s_idle
    , s_wr_addr
    , s_wr_resp
    , s_rd_addr
    , s_rd_data
    , s_respond
  } state_e;

  state_e                        state_q;
  state_e                        state_n;
  logic                          aw_done_q;
  logic                          w_done_q;
  logic [axil_addr_width_gp-1:0] addr_q;
  msg_size_e                     size_q;
  logic [axil_data_width_gp-1:0] wdata_q;
  logic [axil_strb_width_gp-1:0] wstrb_q;
  logic [axil_data_width_gp-1:0] rsp_data_q;
  logic                          rsp_err_q;

  logic [1:0]                    req_off;
  logic [axil_strb_width_gp-1:0] req_strb;
  logic [axil_data_width_gp-1:0] req_wdata;
  logic [7:0]                    rd_byte;
  logic [15:0]                   rd_half;
  logic [axil_data_width_gp-1:0] rd_packed;
  logic                          req_hs;
  logic                          rsp_hs;
  logic                          aw_hs;
  logic                          w_hs;
  logic                          b_hs;
  logic                          ar_hs;
  logic                          r_hs;

  assign req_hs = req_i.req_v && req_i.req_ready;
  assign rsp_hs = req_i.rsp_v && req_i.rsp_ready;
  assign aw_hs  = axil_o.awvalid && axil_o.awready;
  assign w_hs   = axil_o.wvalid && axil_o.wready;
  assign b_hs   = axil_o.bvalid && axil_o.bready;
  assign ar_hs  = axil_o.arvalid && axil_o.arready;
  assign r_hs   = axil_o.rvalid && axil_o.rready;

  // Strobe and lane placement from size and byte offset
  assign req_off = req_i.req_addr[1:0];

  always_comb
  begin
    case (req_i.req_size)
      size_1:  req_strb = 4'b0001 << req_off;
      size_2:  req_strb = 4'b0011 << req_off;
      default: req_strb = '1;
    endcase
  end

  assign req_wdata = req_i.req_data << {req_off, 3'b000};

  // Addressed bytes repeated across the word
  assign rd_byte = axil_o.rdata[{addr_q[1:0], 3'b000} +: 8];
  assign rd_half = axil_o.rdata[{addr_q[1], 4'b0000} +: 16];

  always_comb
  begin
    case (size_q)
      size_1:  rd_packed = {4{rd_byte}};
      size_2:  rd_packed = {2{rd_half}};
      default: rd_packed = axil_o.rdata;
    endcase
  end

  always_comb
  begin
    state_n = state_q;
    case (state_q)
      s_idle:    if (req_hs) state_n = (req_i.req_type == msg_wr) ? s_wr_addr : s_rd_addr;
      s_wr_addr: if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) state_n = s_wr_resp;
      s_wr_resp: if (b_hs) state_n = s_respond;
      s_rd_addr: if (ar_hs) state_n = s_rd_data;
      s_rd_data: if (r_hs) state_n = s_respond;
      s_respond: if (rsp_hs) state_n = s_idle;
      default:   state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q   <= s_idle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      state_q   <= state_n;
      // AW and W may be taken in different cycles
      aw_done_q <= req_hs ? 1'b0 : (aw_done_q || aw_hs);
      w_done_q  <= req_hs ? 1'b0 : (w_done_q || w_hs);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req_hs)
    begin
      addr_q  <= req_i.req_addr;
      size_q  <= req_i.req_size;
      wdata_q <= req_wdata;
      wstrb_q <= req_strb;
    end
    if (state_q == s_wr_resp && b_hs)
    begin
      rsp_data_q <= '0;
      rsp_err_q  <= (axil_o.bresp == resp_slverr_gp);
    end
    else if (r_hs)
    begin
      rsp_data_q <= rd_packed;
      rsp_err_q  <= (axil_o.rresp == resp_slverr_gp);
    end
  end

  assign req_i.req_ready = (state_q == s_idle);
  assign req_i.rsp_v     = (state_q == s_respond);
  assign req_i.rsp_data  = rsp_data_q;
  assign req_i.rsp_err   = rsp_err_q;

  assign axil_o.awaddr  = addr_q;
  assign axil_o.awprot  = 3'b000;
  assign axil_o.awvalid = (state_q == s_wr_addr) && !aw_done_q;
  assign axil_o.wdata   = wdata_q;
  assign axil_o.wstrb   = wstrb_q;
  assign axil_o.wvalid  = (state_q == s_wr_addr) && !w_done_q;
  assign axil_o.bready  = 1'b1;
  assign axil_o.araddr  = addr_q;
  assign axil_o.arprot  = 3'b000;
  assign axil_o.arvalid = (state_q == s_rd_addr);
  assign axil_o.rready  = (state_q == s_rd_data);

endmodule

// File: source/axil_scratchpad.sv
`timescale 1ns/1ps

module axil_scratchpad
#(
  parameter int mem_words_p = 256
)
(
  input  logic     clk_i
  , input  logic   arst_n_i
  , axil_if.slave  axil_i
);
  import mem_bridge_pkg::*;

  localparam int idx_width_lp  = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;
  localparam int word_width_lp = axil_addr_width_gp - 2;

  logic [axil_data_width_gp-1:0] mem_q [mem_words_p];
  logic [word_width_lp-1:0]      wr_word;
  logic [word_width_lp-1:0]      rd_word;
  logic                          wr_in_range;
  logic                          rd_in_range;
  logic                          wr_hs;
  logic                          rd_hs;
  logic                          bvalid_q;
  logic                          rvalid_q;
  logic [1:0]                    bresp_q;
  logic [1:0]                    rresp_q;
  logic [axil_data_width_gp-1:0] rdata_q;

  assign wr_word     = axil_i.awaddr[axil_addr_width_gp-1:2];
  assign rd_word     = axil_i.araddr[axil_addr_width_gp-1:2];
  assign wr_in_range = wr_word < mem_words_p;
  assign rd_in_range = rd_word < mem_words_p;

  // AW and W taken together, none while B is pending
  assign wr_hs = axil_i.awvalid && axil_i.wvalid && !bvalid_q;
  assign rd_hs = axil_i.arvalid && !rvalid_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < mem_words_p; i++)
        mem_q[i] <= '0;
    end
    else if (wr_hs && wr_in_range)
    begin
      for (int b = 0; b < axil_strb_width_gp; b++)
        if (axil_i.wstrb[b])
          mem_q[wr_word[idx_width_lp-1:0]][b*8 +: 8] <= axil_i.wdata[b*8 +: 8];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      bvalid_q <= wr_hs || (bvalid_q && !axil_i.bready);
      rvalid_q <= rd_hs || (rvalid_q && !axil_i.rready);
    end
  end

  // Only loaded on a new handshake, so B and R hold under back-pressure
  always_ff @(posedge clk_i)
  begin
    if (wr_hs)
      bresp_q <= wr_in_range ? resp_okay_gp : resp_slverr_gp;
    if (rd_hs)
    begin
      rresp_q <= rd_in_range ? resp_okay_gp : resp_slverr_gp;
      rdata_q <= rd_in_range ? mem_q[rd_word[idx_width_lp-1:0]] : '0;
    end
  end

  assign axil_i.awready = wr_hs;
  assign axil_i.wready  = wr_hs;
  assign axil_i.bvalid  = bvalid_q;
  assign axil_i.bresp   = bresp_q;
  assign axil_i.arready = !rvalid_q;
  assign axil_i.rvalid  = rvalid_q;
  assign axil_i.rresp   = rresp_q;
  assign axil_i.rdata   = rdata_q;

endmodule

// File: source/mem_bridge_pkg.sv
package mem_bridge_pkg;

  // AXI-Lite bus geometry
  parameter int axil_data_width_gp = 32;
  parameter int axil_addr_width_gp = 16;
  parameter int axil_strb_width_gp = axil_data_width_gp / 8;

  // AXI response codes
  parameter logic [1:0] resp_okay_gp   = 2'b00;
  parameter logic [1:0] resp_slverr_gp = 2'b10;

  // Access size in bytes, aligned to its own size
  typedef enum logic [1:0]
  {
    size_1   = 2'b00
    , size_2 = 2'b01
    , size_4 = 2'b10
  } msg_size_e;

  // Access direction
  typedef enum logic
  {
    msg_rd   = 1'b0
    , msg_wr = 1'b1
  } msg_type_e;

endpackage

// File: source/mem_bridge_top.sv
`timescale 1ns/1ps

module mem_bridge_top
#(
  parameter int mem_words_p = 256
)
(
  input  logic                                                clk_i
  , input  logic                                              arst_n_i

  // Requester port 0
  , input  logic                                              p0_req_v_i
  , input  mem_bridge_pkg::msg_type_e                         p0_req_type_i
  , input  mem_bridge_pkg::msg_size_e                         p0_req_size_i
  , input  logic [mem_bridge_pkg::axil_addr_width_gp-1:0]     p0_req_addr_i
  , input  logic [mem_bridge_pkg::axil_data_width_gp-1:0]     p0_req_data_i
  , input  logic                                              p0_rsp_ready_i
  , output logic                                              p0_req_ready_o
  , output logic                                              p0_rsp_v_o
  , output logic [mem_bridge_pkg::axil_data_width_gp-1:0]     p0_rsp_data_o
  , output logic                                              p0_rsp_err_o

  // Requester port 1
  , input  logic                                              p1_req_v_i
  , input  mem_bridge_pkg::msg_type_e                         p1_req_type_i
  , input  mem_bridge_pkg::msg_size_e                         p1_req_size_i
  , input  logic [mem_bridge_pkg::axil_addr_width_gp-1:0]     p1_req_addr_i
  , input  logic [mem_bridge_pkg::axil_data_width_gp-1:0]     p1_req_data_i
  , input  logic                                              p1_rsp_ready_i
  , output logic                                              p1_req_ready_o
  , output logic                                              p1_rsp_v_o
  , output logic [mem_bridge_pkg::axil_data_width_gp-1:0]     p1_rsp_data_o
  , output logic                                              p1_rsp_err_o
);

  mem_port_if p0_if ();
  mem_port_if p1_if ();
  mem_port_if mst_if ();
  axil_if     axil_bus ();

  assign p0_if.req_v     = p0_req_v_i;
  assign p0_if.req_type  = p0_req_type_i;
  assign p0_if.req_size  = p0_req_size_i;
  assign p0_if.req_addr  = p0_req_addr_i;
  assign p0_if.req_data  = p0_req_data_i;
  assign p0_if.rsp_ready = p0_rsp_ready_i;
  assign p0_req_ready_o  = p0_if.req_ready;
  assign p0_rsp_v_o      = p0_if.rsp_v;
  assign p0_rsp_data_o   = p0_if.rsp_data;
  assign p0_rsp_err_o    = p0_if.rsp_err;

  assign p1_if.req_v     = p1_req_v_i;
  assign p1_if.req_type  = p1_req_type_i;
  assign p1_if.req_size  = p1_req_size_i;
  assign p1_if.req_addr  = p1_req_addr_i;
  assign p1_if.req_data  = p1_req_data_i;
  assign p1_if.rsp_ready = p1_rsp_ready_i;
  assign p1_req_ready_o  = p1_if.req_ready;
  assign p1_rsp_v_o      = p1_if.rsp_v;
  assign p1_rsp_data_o   = p1_if.rsp_data;
  assign p1_rsp_err_o    = p1_if.rsp_err;

  req_arbiter i_req_arbiter
  (
    .clk_i      (clk_i)
    , .arst_n_i (arst_n_i)
    , .p0_i     (p0_if.server)
    , .p1_i     (p1_if.server)
    , .mst_o    (mst_if.client)
  );

  axil_master i_axil_master
  (
    .clk_i      (clk_i)
    , .arst_n_i (arst_n_i)
    , .req_i    (mst_if.server)
    , .axil_o   (axil_bus.master)
  );

  axil_scratchpad
  #(
    .mem_words_p (mem_words_p)
  )
  i_axil_scratchpad
  (
    .clk_i      (clk_i)
    , .arst_n_i (arst_n_i)
    , .axil_i   (axil_bus.slave)
  );

endmodule

// File: source/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if;
  import mem_bridge_pkg::*;

  // Request side
  logic                          req_v;
  logic                          req_ready;
  msg_type_e                     req_type;
  msg_size_e                     req_size;
  logic [axil_addr_width_gp-1:0] req_addr;
  logic [axil_data_width_gp-1:0] req_data;

  // Response side
  logic                          rsp_v;
  logic                          rsp_ready;
  logic [axil_data_width_gp-1:0] rsp_data;
  logic                          rsp_err;

  // Client issues requests and sinks responses
  modport client
  (
    output req_v, req_type, req_size, req_addr, req_data, rsp_ready
    , input req_ready, rsp_v, rsp_data, rsp_err
  );

  modport server
  (
    input req_v, req_type, req_size, req_addr, req_data, rsp_ready
    , output req_ready, rsp_v, rsp_data, rsp_err
  );

endinterface

// File: source/req_arbiter.sv
`timescale 1ns/1ps

module req_arbiter
(
  input  logic         clk_i
  , input  logic       arst_n_i
  , mem_port_if.server p0_i
  , mem_port_if.server p1_i
  , mem_port_if.client mst_o
);

  logic locked_q;
  // Port that owns the master while locked
  logic gnt_q;
  // Port favored at the next pick
  logic prio_q;
  logic pick;
  logic sel;

  // Round robin among the valid ports
  always_comb
  begin
    if (prio_q == 1'b0)
      pick = !p0_i.req_v && p1_i.req_v;
    else
      pick = p1_i.req_v || !p0_i.req_v;
  end

  assign sel = locked_q ? gnt_q : pick;

  // Request path, closed while a grant is held
  assign mst_o.req_v    = !locked_q && (sel ? p1_i.req_v : p0_i.req_v);
  assign mst_o.req_type = sel ? p1_i.req_type : p0_i.req_type;
  assign mst_o.req_size = sel ? p1_i.req_size : p0_i.req_size;
  assign mst_o.req_addr = sel ? p1_i.req_addr : p0_i.req_addr;
  assign mst_o.req_data = sel ? p1_i.req_data : p0_i.req_data;

  assign p0_i.req_ready = !locked_q && !sel && mst_o.req_ready;
  assign p1_i.req_ready = !locked_q && sel && mst_o.req_ready;

  // Response goes back to the granted port only
  assign mst_o.rsp_ready = locked_q && (gnt_q ? p1_i.rsp_ready : p0_i.rsp_ready);

  assign p0_i.rsp_v    = locked_q && !gnt_q && mst_o.rsp_v;
  assign p1_i.rsp_v    = locked_q && gnt_q && mst_o.rsp_v;
  assign p0_i.rsp_data = mst_o.rsp_data;
  assign p1_i.rsp_data = mst_o.rsp_data;
  assign p0_i.rsp_err  = mst_o.rsp_err;
  assign p1_i.rsp_err  = mst_o.rsp_err;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      locked_q <= 1'b0;
      gnt_q    <= 1'b0;
      prio_q   <= 1'b0;
    end
    else if (mst_o.req_v && mst_o.req_ready)
    begin
      locked_q <= 1'b1;
      gnt_q    <= sel;
    end
    else if (mst_o.rsp_v && mst_o.rsp_ready)
    begin
      // Release and hand priority to the other port
      locked_q <= 1'b0;
      prio_q   <= !gnt_q;
    end
  end

endmodule

// File: verification/mem_bridge_asserts.sv
`timescale 1ns/1ps

module mem_bridge_asserts
(
  input  logic                                            clk_i
  , input  logic                                          arst_n_i
  , input  logic                                          awvalid_i
  , input  logic                                          awready_i
  , input  logic                                          wvalid_i
  , input  logic                                          wready_i
  , input  logic                                          arvalid_i
  , input  logic                                          arready_i
  , input  logic                                          req_v_i
  , input  logic                                          req_ready_i
  , input  logic                                          rsp_v_i
  , input  logic                                          rsp_ready_i
  , input  logic [mem_bridge_pkg::axil_data_width_gp-1:0] rsp_data_i
  , input  logic                                          rsp_err_i
);

  logic pending_q;

  property hold_until_ready(valid, ready);
    @(posedge clk_i) disable iff (!arst_n_i)
      valid && !ready |=> valid;
  endproperty

  aw_hold_a: assert property (hold_until_ready(awvalid_i, awready_i))
    else $error("AWVALID dropped before AWREADY");
  w_hold_a: assert property (hold_until_ready(wvalid_i, wready_i))
    else $error("WVALID dropped before WREADY");
  ar_hold_a: assert property (hold_until_ready(arvalid_i, arready_i))
    else $error("ARVALID dropped before ARREADY");

  // Response payload frozen while stalled
  rsp_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_v_i && !rsp_ready_i |=> rsp_v_i && $stable(rsp_data_i) && $stable(rsp_err_i))
    else $error("Response changed before rsp_ready");

  // Set on request accept, cleared when the response is taken
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pending_q <= 1'b0;
    else if (req_v_i && req_ready_i)
      pending_q <= 1'b1;
    else if (rsp_v_i && rsp_ready_i)
      pending_q <= 1'b0;
  end

  // No new request while one is in flight
  busy_while_pending_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pending_q |-> !req_ready_i)
    else $error("req_ready high while a request is in flight");

endmodule

bind axil_master mem_bridge_asserts i_mem_bridge_asserts
(
  .clk_i         (clk_i)
  , .arst_n_i    (arst_n_i)
  , .awvalid_i   (axil_o.awvalid)
  , .awready_i   (axil_o.awready)
  , .wvalid_i    (axil_o.wvalid)
  , .wready_i    (axil_o.wready)
  , .arvalid_i   (axil_o.arvalid)
  , .arready_i   (axil_o.arready)
  , .req_v_i     (req_i.req_v)
  , .req_ready_i (req_i.req_ready)
  , .rsp_v_i     (req_i.rsp_v)
  , .rsp_ready_i (req_i.rsp_ready)
  , .rsp_data_i  (req_i.rsp_data)
  , .rsp_err_i   (req_i.rsp_err)
);

// File: verification/mem_bridge_testdata.txt
// Per port: valid type size addr wdata exp_data exp_err, port 0 first and then port 1
// type 0 read 1 write; size 0 byte 1 halfword 2 word; exp_data applies to reads only
1 1 2 0000 11223344 00000000 0  1 1 2 0010 a5a5a5a5 00000000 0
1 0 2 0000 00000000 11223344 0  1 0 2 0010 00000000 a5a5a5a5 0
1 1 0 0001 aabbccee 00000000 0  1 1 0 0013 ffffff5a 00000000 0
1 1 0 0003 00000077 00000000 0  1 1 0 0010 ffffff3c 00000000 0
1 1 0 0000 00000001 00000000 0  1 1 0 0012 00000000 00000000 0
1 1 0 0002 000000cd 00000000 0  1 1 0 0011 00000099 00000000 0
1 0 2 0000 00000000 77cdee01 0  1 0 2 0010 00000000 5a00993c 0
1 1 1 0020 0000beef 00000000 0  1 1 1 0032 ffffcafe 00000000 0
1 1 1 0022 00001234 00000000 0  1 1 1 0030 99995678 00000000 0
1 0 2 0020 00000000 1234beef 0  1 0 2 0030 00000000 cafe5678 0
1 0 0 0000 00000000 01010101 0  1 0 0 0011 00000000 99999999 0
1 0 0 0002 00000000 cdcdcdcd 0  1 0 0 0013 00000000 5a5a5a5a 0
1 0 0 0001 00000000 eeeeeeee 0  1 0 0 0012 00000000 00000000 0
1 0 0 0003 00000000 77777777 0  1 0 0 0010 00000000 3c3c3c3c 0
1 0 1 0020 00000000 beefbeef 0  1 0 1 0032 00000000 cafecafe 0
1 0 1 0022 00000000 12341234 0  1 0 1 0030 00000000 56785678 0
1 1 2 0400 deadbeef 00000000 1  1 0 2 0404 00000000 00000000 1
1 0 0 0401 00000000 00000000 1  1 1 0 fffc 00000055 00000000 1
1 0 2 0000 00000000 77cdee01 0  1 0 2 03fc 00000000 00000000 0
1 1 2 03fc cafef00d 00000000 0  0 0 0 0000 00000000 00000000 0
0 0 0 0000 00000000 00000000 0  1 0 2 03fc 00000000 cafef00d 0

// File: verification/tb_mem_bridge.sv
`timescale 1ns/1ps

module tb_mem_bridge;
  import mem_bridge_pkg::*;

  localparam int clk_period_lp  = 100;
  localparam int drive_delay_lp = 10;
  localparam int timeout_lp     = 200;
  localparam int fields_lp      = 7;
  localparam int max_steps_lp   = 32;

  logic                          clk;
  logic                          arst_n;
  logic                          req_v     [2];
  msg_type_e                     req_type  [2];
  msg_size_e                     req_size  [2];
  logic [axil_addr_width_gp-1:0] req_addr  [2];
  logic [axil_data_width_gp-1:0] req_data  [2];
  logic                          rsp_ready [2];
  logic                          req_ready [2];
  logic                          rsp_v     [2];
  logic [axil_data_width_gp-1:0] rsp_data  [2];
  logic                          rsp_err   [2];

  // One step is two ports of seven fields each
  logic [31:0] vec_mem [fields_lp*2*max_steps_lp];
  integer      seed;
  int          mismatch_cnt;
  int          protocol_cnt;
  int          timeout_cnt;
  int          step;
  int          base;

  mem_bridge_top i_mem_bridge_top
  (
    .clk_i            (clk)
    , .arst_n_i       (arst_n)
    , .p0_req_v_i     (req_v[0])
    , .p0_req_type_i  (req_type[0])
    , .p0_req_size_i  (req_size[0])
    , .p0_req_addr_i  (req_addr[0])
    , .p0_req_data_i  (req_data[0])
    , .p0_rsp_ready_i (rsp_ready[0])
    , .p0_req_ready_o (req_ready[0])
    , .p0_rsp_v_o     (rsp_v[0])
    , .p0_rsp_data_o  (rsp_data[0])
    , .p0_rsp_err_o   (rsp_err[0])
    , .p1_req_v_i     (req_v[1])
    , .p1_req_type_i  (req_type[1])
    , .p1_req_size_i  (req_size[1])
    , .p1_req_addr_i  (req_addr[1])
    , .p1_req_data_i  (req_data[1])
    , .p1_rsp_ready_i (rsp_ready[1])
    , .p1_req_ready_o (req_ready[1])
    , .p1_rsp_v_o     (rsp_v[1])
    , .p1_rsp_data_o  (rsp_data[1])
    , .p1_rsp_err_o   (rsp_err[1])
  );

  always #(clk_period_lp/2) clk = ~clk;

  task automatic compare_word(input int p, input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp)
    begin
      $display("MISMATCH at %0t ns: port %0d step %0d %s expected %08h actual %08h",
               $time, p, step, what, exp, act);
      mismatch_cnt++;
    end
  endtask

  // Issue one request on port p and take its response
  task automatic run_port(input int p, input int idx);
    logic        is_rd;
    logic [31:0] held_data;
    logic        held_err;
    int          cycles;
    int          hold;
    if (vec_mem[idx][0] == 1'b0)
      return;
    is_rd       = (vec_mem[idx+1][0] == 1'b0);
    req_v[p]    = 1'b1;
    req_type[p] = msg_type_e'(vec_mem[idx+1][0]);
    req_size[p] = msg_size_e'(vec_mem[idx+2][1:0]);
    req_addr[p] = vec_mem[idx+3][axil_addr_width_gp-1:0];
    req_data[p] = vec_mem[idx+4];

    // Ready seen here means the handshake lands on the next edge
    cycles = 0;
    @(negedge clk);
    while (!req_ready[p] && cycles < timeout_lp)
    begin
      cycles++;
      @(negedge clk);
    end
    if (!req_ready[p])
    begin
      $display("Timeout: port %0d request was not accepted in %0d cycles", p, timeout_lp);
      timeout_cnt++;
      req_v[p] = 1'b0;
      return;
    end
    @(posedge clk);
    #(drive_delay_lp);
    req_v[p] = 1'b0;

    cycles = 0;
    @(negedge clk);
    while (!rsp_v[p] && cycles < timeout_lp)
    begin
      cycles++;
      @(negedge clk);
    end
    if (!rsp_v[p])
    begin
      $display("Timeout: port %0d got no response in %0d cycles", p, timeout_lp);
      timeout_cnt++;
      return;
    end

    // Stall the response for 0 to 3 cycles
    hold      = $unsigned($random(seed)) % 4;
    held_data = rsp_data[p];
    held_err  = rsp_err[p];
    repeat (hold)
    begin
      @(negedge clk);
      if (!rsp_v[p] || req_ready[0] || req_ready[1])
      begin
        $display("Error at %0t ns: port %0d response dropped or new request open during stall",
                 $time, p);
        protocol_cnt++;
      end
      compare_word(p, "held rsp_data", held_data, rsp_data[p]);
      compare_word(p, "held rsp_err", {31'd0, held_err}, {31'd0, rsp_err[p]});
    end
    @(posedge clk);
    #(drive_delay_lp);
    rsp_ready[p] = 1'b1;
    @(negedge clk);
    if (!rsp_v[p])
    begin
      $display("Error at %0t ns: port %0d response vanished before it was accepted", $time, p);
      protocol_cnt++;
    end
    compare_word(p, "held rsp_data", held_data, rsp_data[p]);
    if (is_rd)
      compare_word(p, "rsp_data", vec_mem[idx+5], rsp_data[p]);
    compare_word(p, "rsp_err", {31'd0, vec_mem[idx+6][0]}, {31'd0, rsp_err[p]});
    @(posedge clk);
    #(drive_delay_lp);
    rsp_ready[p] = 1'b0;
  endtask

  initial
  begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    seed         = 32'hd8ae;
    mismatch_cnt = 0;
    protocol_cnt = 0;
    timeout_cnt  = 0;
    for (int p = 0; p < 2; p++)
    begin
      req_v[p]     = 1'b0;
      req_type[p]  = msg_rd;
      req_size[p]  = size_1;
      req_addr[p]  = '0;
      req_data[p]  = '0;
      rsp_ready[p] = 1'b0;
    end
    $readmemh("verification/mem_bridge_testdata.txt", vec_mem);

    repeat (5) @(posedge clk);
    #(drive_delay_lp);
    arst_n = 1'b1;
    @(negedge clk);
    if (rsp_v[0] || rsp_v[1])
    begin
      $display("Error: a response was valid right after reset");
      protocol_cnt++;
    end

    for (step = 0; step < max_steps_lp; step++)
    begin
      base = step * fields_lp * 2;
      if ($isunknown(vec_mem[base]) || timeout_cnt != 0)
        break;
      @(posedge clk);
      #(drive_delay_lp);
      fork
        run_port(0, base);
        run_port(1, base + fields_lp);
      join
    end
    if (step == 0)
    begin
      $display("Error: the data file gave no test steps");
      protocol_cnt++;
    end

    $display("Errors: %0d mismatches, %0d protocol, %0d timeouts in %0d steps",
             mismatch_cnt, protocol_cnt, timeout_cnt, step);
    if (mismatch_cnt == 0 && protocol_cnt == 0 && timeout_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule
